//--- vlog.f
+incdir+include
design/lsq_pkg.sv
design/lsq_dispatch.sv
design/store_queue.sv
design/store_commit.sv
design/lsq_top.sv
testbench/tb_clock_gen.sv
testbench/lsq_checker.sv
testbench/lsq_tb.sv

//--- testbench/lsq_tb.sv
/*
 * LSQ testbench
 * Random dispatch, bus and memory traffic on falling edges,
 * a fill and flush sequence, a final drain and a watchdog
 */
`timescale 1ns/10ps
`default_nettype none
`include "lsq_consts.svh"

module lsq_tb;
	import lsq_pkg::*;

	localparam int RANDOM_CYCLES = 600; // Per random phase
	localparam int FILL_CYCLES   = 3 * `LSQ_SQ_DEPTH;
	localparam int DRAIN_CYCLES  = 12 * `LSQ_SQ_DEPTH;
	localparam int STIM_CYCLES   = 5 + 2 * RANDOM_CYCLES + FILL_CYCLES + DRAIN_CYCLES + 4;
	localparam int WATCHDOG_NS   = (STIM_CYCLES + 200) * 20;

	logic         clock, reset;
	logic         dispatch_valid, opb_valid, rega_valid, bus_valid, mispredict, mem_accept;
	logic [5:0]   dispatch_op;
	rob_idx_t     dispatch_rob_idx, retire_head, result_rob_idx;
	prf_tag_t     dispatch_dest_tag, bus_tag, result_tag;
	word_t        opa, opb, rega, bus_value, result_value, mem_address, mem_data;
	logic         result_valid, sq_full;
	bus_command_t mem_command;

	integer   seed = 32'h4bdbd2b1;
	logic     retire_on;     // Retire head tracks the oldest store
	logic     store_waiting; // Memory refused the request last cycle
	rob_idx_t next_rob_idx;
	rob_idx_t robs[$];       // Stores the DUT still holds, oldest first

	tb_clock_gen clock_gen_i (.clock, .reset);
	lsq_top lsq_top_i (.*);
	lsq_checker checker_i (.*);

	// Follow the queue so retire_head can be aimed at the head store
	always @(posedge clock) begin
		if (reset || mispredict) begin
			robs.delete();
			store_waiting = 1'b0;
		end else begin
			if (mem_command == BUS_STORE && mem_accept) void'(robs.pop_front());
			if (dispatch_valid && dispatch_op == `LSQ_OP_STQ) robs.push_back(dispatch_rob_idx);
			store_waiting = mem_command == BUS_STORE && !mem_accept;
		end
	end

	task automatic quiet_inputs();
		dispatch_valid = 1'b0;
		mispredict     = 1'b0;
		bus_valid      = 1'b0;
		mem_accept     = 1'b1;
	endtask

	task automatic pick_operand(output word_t value, output logic valid, input logic ready);
		value = {$random(seed), $random(seed)};
		valid = ready || (($random(seed) & 1) == 1);
		if (!valid) value[$bits(prf_tag_t)-1:0] = prf_tag_t'($random(seed) & 7); // Tag to wait on
	endtask

	task automatic dispatch(input logic [5:0] op, input logic ready);
		dispatch_valid    = 1'b1;
		dispatch_op       = op;
		dispatch_rob_idx  = next_rob_idx;
		dispatch_dest_tag = prf_tag_t'($random(seed));
		opa               = {$random(seed), $random(seed)};
		pick_operand(opb, opb_valid, ready);
		pick_operand(rega, rega_valid, ready);
		next_rob_idx++;
	endtask

	task automatic aim_retire_head();
		if (robs.size() == 0) retire_head = rob_idx_t'($random(seed));
		else if (retire_on) retire_head = robs[0];
		else retire_head = robs[0] ^ rob_idx_t'(16); // Parked away from the head store
	endtask

	task automatic random_cycle();
		int   pick;
		logic flush;
		@(negedge clock);
		pick  = $random(seed) & 7;
		flush = !mispredict && (($random(seed) & 63) == 0); // One-cycle pulse
		quiet_inputs();
		if (pick < 2) dispatch(`LSQ_OP_LDA, 1'b0);
		else if (pick < 5 && !sq_full) dispatch(`LSQ_OP_STQ, 1'b0);
		else if (pick == 5) dispatch(6'h2f, 1'b1); // Conditional store decodes as no op
		mispredict = flush;
		bus_valid  = ($random(seed) & 1) == 1;
		bus_tag    = prf_tag_t'($random(seed) & 7);
		bus_value  = {$random(seed), $random(seed)};
		mem_accept = ($random(seed) & 3) != 0;
		if (!store_waiting) begin
			if (($random(seed) & 15) == 0) retire_on = !retire_on;
			aim_retire_head();
		end
	endtask

	//////////////////////////////////////////////////
	// Fill with retirement held off, then flush
	//////////////////////////////////////////////////
	task automatic fill_and_flush();
		retire_on = 1'b0;
		while (!sq_full) begin
			@(negedge clock);
			quiet_inputs();
			if (!store_waiting) aim_retire_head();
			dispatch(`LSQ_OP_STQ, 1'b1);
		end
		repeat (3) begin
			@(negedge clock);
			quiet_inputs();
		end
		@(negedge clock);
		quiet_inputs();
		dispatch(`LSQ_OP_LDA, 1'b1);
		mispredict = 1'b1;
		retire_on  = 1'b1;
	endtask

	task automatic drain();
		int step;
		step      = 0;
		retire_on = 1'b1;
		while (robs.size() != 0) begin
			@(negedge clock);
			quiet_inputs();
			bus_valid = 1'b1;
			bus_tag   = prf_tag_t'(step % 8); // Sweep every tag in use
			bus_value = {$random(seed), $random(seed)};
			aim_retire_head();
			step++;
		end
	endtask

	task automatic report_totals();
		$display("Errors: %0d wrong values, %0d other failures (%0d stores, %0d LDA results)",
			checker_i.value_errors, checker_i.other_errors, checker_i.stores_written,
			checker_i.lda_results);
	endtask

	initial begin
		quiet_inputs();
		dispatch_op       = '0;
		dispatch_rob_idx  = '0;
		dispatch_dest_tag = '0;
		opa               = '0;
		opb               = '0;
		opb_valid         = 1'b0;
		rega              = '0;
		rega_valid        = 1'b0;
		bus_tag           = '0;
		bus_value         = '0;
		retire_head       = '0;
		retire_on         = 1'b1;
		next_rob_idx      = '0;
		wait (reset === 1'b0);
		repeat (RANDOM_CYCLES) random_cycle();
		fill_and_flush();
		repeat (RANDOM_CYCLES) random_cycle();
		drain();
		repeat (4) begin
			@(negedge clock);
			quiet_inputs();
		end
		checker_i.check_drained();
		report_totals();
		if (checker_i.value_errors == 0 && checker_i.other_errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns before the run finished", WATCHDOG_NS);
		report_totals();
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- testbench/lsq_checker.sv
/*
 * LSQ checker
 * Shadow model of the store queue built from the observed ports;
 * compares memory port, LDA result and full flag on every rising edge
 */
`timescale 1ns/10ps
`default_nettype none
`include "lsq_consts.svh"

module lsq_checker (
	input wire                         clock, reset,
	input wire                         dispatch_valid, opb_valid, rega_valid,
	input wire  [5:0]                  dispatch_op,
	input wire  lsq_pkg::rob_idx_t     dispatch_rob_idx, retire_head, result_rob_idx,
	input wire  lsq_pkg::prf_tag_t     dispatch_dest_tag, bus_tag, result_tag,
	input wire  lsq_pkg::word_t        opa, opb, rega, bus_value, result_value,
	input wire  lsq_pkg::word_t        mem_address, mem_data,
	input wire                         bus_valid, mispredict, mem_accept,
	input wire                         result_valid, sq_full,
	input wire  lsq_pkg::bus_command_t mem_command
);
	import lsq_pkg::*;

	localparam int TAG_W = $bits(prf_tag_t);

	typedef struct packed {
		rob_idx_t rob_idx;
		word_t    opa;
		word_t    opb;
		logic     opb_ok;
		word_t    data;
		logic     data_ok;
	} store_entry_t;

	store_entry_t shadow[$]; // Unwritten stores with the oldest in front
	int value_errors   = 0;
	int other_errors   = 0;
	int stores_written = 0;
	int lda_results    = 0;

	logic     lda_due;      // LDA dispatched last cycle
	prf_tag_t lda_tag;
	rob_idx_t lda_rob_idx;
	word_t    lda_value;
	logic     held;         // Request refused by memory last cycle
	word_t    held_address;
	word_t    held_data;

	// Expected effective address and data of a store
	function automatic logic [2*`LSQ_XLEN-1:0] expected_store(word_t base, word_t offset,
			word_t value);
		return {base + offset, value};
	endfunction

	// Waiting operand whose tag is on the result bus this cycle
	function automatic logic bus_hit(word_t field, logic ok);
		return bus_valid && !ok && bus_tag == field[TAG_W-1:0];
	endfunction

	task automatic compare_value(string name, word_t expected, word_t actual);
		if (actual !== expected) begin
			value_errors++;
			$display("ERROR at %0t: %s expected %h, actual %h", $time, name, expected, actual);
		end
	endtask

	task check_drained();
		if (shadow.size() != 0) begin
			other_errors++;
			$display("%0d dispatched stores were never written to memory", shadow.size());
		end
	endtask

	always @(posedge clock) begin
		store_entry_t           entry;
		logic                   issue;
		logic [2*`LSQ_XLEN-1:0] expected;
		if (reset) begin
			shadow.delete();
			lda_due = 1'b0;
			held    = 1'b0;
		end else begin
			//////////////////////////////////////////////////
			// Outputs of the cycle that ends now
			//////////////////////////////////////////////////
			compare_value("result_valid", word_t'(lda_due), word_t'(result_valid));
			if (lda_due) begin
				compare_value("result_tag", word_t'(lda_tag), word_t'(result_tag));
				compare_value("result_rob_idx", word_t'(lda_rob_idx), word_t'(result_rob_idx));
				compare_value("result_value", lda_value, result_value);
				lda_results++;
			end
			issue = 1'b0;
			entry = '0;
			if (shadow.size() != 0 && !mispredict) begin
				entry = shadow[0];
				issue = entry.opb_ok && entry.data_ok && entry.rob_idx == retire_head;
			end
			expected = expected_store(entry.opa, entry.opb, entry.data);
			compare_value("mem_command", word_t'(issue ? BUS_STORE : BUS_NONE),
				word_t'(mem_command));
			if (issue) begin
				compare_value("mem_address", expected[2*`LSQ_XLEN-1:`LSQ_XLEN], mem_address);
				compare_value("mem_data", expected[`LSQ_XLEN-1:0], mem_data);
			end
			if (held && !mispredict && (mem_command !== BUS_STORE ||
					mem_address !== held_address || mem_data !== held_data)) begin
				other_errors++;
				$display("At %0t the store request changed while memory held it off", $time);
			end
			compare_value("sq_full", word_t'(shadow.size() == `LSQ_SQ_DEPTH), word_t'(sq_full));

			//////////////////////////////////////////////////
			// Advance the model
			//////////////////////////////////////////////////
			held         = mem_command == BUS_STORE && !mem_accept;
			held_address = mem_address;
			held_data    = mem_data;
			if (mispredict) begin
				shadow.delete(); // Flushed stores must never reach memory
			end else begin
				foreach (shadow[i]) begin
					entry = shadow[i];
					if (bus_hit(entry.opb, entry.opb_ok)) begin
						entry.opb    = bus_value;
						entry.opb_ok = 1'b1;
					end
					if (bus_hit(entry.data, entry.data_ok)) begin
						entry.data    = bus_value;
						entry.data_ok = 1'b1;
					end
					shadow[i] = entry;
				end
				if (issue && mem_accept) begin
					void'(shadow.pop_front());
					stores_written++;
				end
				if (dispatch_valid && dispatch_op == `LSQ_OP_STQ) begin
					entry.rob_idx = dispatch_rob_idx;
					entry.opa     = opa;
					entry.opb     = bus_hit(opb, opb_valid) ? bus_value : opb;
					entry.opb_ok  = opb_valid || bus_hit(opb, opb_valid);
					entry.data    = bus_hit(rega, rega_valid) ? bus_value : rega;
					entry.data_ok = rega_valid || bus_hit(rega, rega_valid);
					shadow.push_back(entry);
				end
			end
			lda_due     = dispatch_valid && dispatch_op == `LSQ_OP_LDA; // Survives a flush
			lda_tag     = dispatch_dest_tag;
			lda_rob_idx = dispatch_rob_idx;
			lda_value   = opa + (bus_hit(opb, opb_valid) ? bus_value : opb);
		end
	end

endmodule

`default_nettype wire

//--- testbench/tb_clock_gen.sv
/*
 * Testbench clock and reset
 * 20 ns clock, reset held high over the first 5 rising edges
 */
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
	output logic clock,
	output logic reset
);
	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	initial begin
		reset = 1'b1;
		repeat (5) @(posedge clock);
		@(negedge clock);
		reset = 1'b0; // Released on a falling edge
	end

endmodule

`default_nettype wire

//--- design/lsq_top.sv
/*
 * Load/store queue, store side
 * Dispatch, store queue and commit wired together
 */
`timescale 1ns/10ps
`default_nettype none

module lsq_top (
	input  wire                     clock,
	input  wire                     reset,
	input  wire                     dispatch_valid,
	input  wire  [5:0]              dispatch_op,
	input  wire  lsq_pkg::rob_idx_t dispatch_rob_idx,
	input  wire  lsq_pkg::prf_tag_t dispatch_dest_tag,
	input  wire  lsq_pkg::word_t    opa,
	input  wire  lsq_pkg::word_t    opb,
	input  wire                     opb_valid,
	input  wire  lsq_pkg::word_t    rega,
	input  wire                     rega_valid,
	input  wire                     bus_valid,
	input  wire  lsq_pkg::prf_tag_t bus_tag,
	input  wire  lsq_pkg::word_t    bus_value,
	input  wire  lsq_pkg::rob_idx_t retire_head,
	input  wire                     mispredict,
	input  wire                     mem_accept,
	output logic                    result_valid,
	output lsq_pkg::prf_tag_t       result_tag,
	output lsq_pkg::rob_idx_t       result_rob_idx,
	output lsq_pkg::word_t          result_value,
	output lsq_pkg::bus_command_t   mem_command,
	output lsq_pkg::word_t          mem_address,
	output lsq_pkg::word_t          mem_data,
	output logic                    sq_full
);
	import lsq_pkg::*;

	// Dispatch to store queue
	logic     sq_push;
	rob_idx_t push_rob_idx;
	word_t    push_opa;
	word_t    push_opb;
	logic     push_opb_valid;
	word_t    push_rega;
	logic     push_rega_valid;

	// Store queue head and pop
	logic     head_valid;
	logic     head_ready;
	rob_idx_t head_rob_idx;
	word_t    head_opa;
	word_t    head_opb;
	word_t    head_data;
	logic     sq_pop;

	lsq_dispatch lsq_dispatch_i (
		.clock, .reset, .dispatch_valid, .dispatch_op, .dispatch_rob_idx,
		.dispatch_dest_tag, .opa, .opb, .opb_valid, .rega, .rega_valid,
		.bus_valid, .bus_tag, .bus_value, .mispredict,
		.sq_push, .push_rob_idx, .push_opa, .push_opb, .push_opb_valid,
		.push_rega, .push_rega_valid,
		.result_valid, .result_tag, .result_rob_idx, .result_value
	);

	store_queue store_queue_i (
		.clock, .reset, .sq_push, .push_rob_idx, .push_opa, .push_opb,
		.push_opb_valid, .push_rega, .push_rega_valid,
		.bus_valid, .bus_tag, .bus_value, .mispredict, .sq_pop,
		.head_valid, .head_ready, .head_rob_idx, .head_opa, .head_opb,
		.head_data, .sq_full
	);

	store_commit store_commit_i (
		.head_valid, .head_ready, .head_rob_idx, .head_opa, .head_opb,
		.head_data, .retire_head, .mem_accept,
		.sq_pop, .mem_command, .mem_address, .mem_data
	);

endmodule

`default_nettype wire

//--- design/store_commit.sv
/*
 * Store commit
 * Sends the head store to memory once it is retired and complete
 */
`timescale 1ns/10ps
`default_nettype none

module store_commit (
	input  wire                     head_valid,
	input  wire                     head_ready,
	input  wire  lsq_pkg::rob_idx_t head_rob_idx,
	input  wire  lsq_pkg::word_t    head_opa,
	input  wire  lsq_pkg::word_t    head_opb,
	input  wire  lsq_pkg::word_t    head_data,
	input  wire  lsq_pkg::rob_idx_t retire_head,
	input  wire                     mem_accept,
	output logic                    sq_pop,
	output lsq_pkg::bus_command_t   mem_command,
	output lsq_pkg::word_t          mem_address,
	output lsq_pkg::word_t          mem_data
);
	import lsq_pkg::*;

	logic  store_issue;
	word_t effective_address;

	// Head store is at the retire point with both operands present
	assign store_issue = head_valid && head_ready && head_rob_idx == retire_head;

	assign effective_address = head_opa + head_opb;

	//////////////////////////////////////////////////
	// Memory write request
	//////////////////////////////////////////////////
	always_comb begin
		mem_command = BUS_NONE;
		mem_address = '0;
		mem_data    = '0;
		if (store_issue) begin
			mem_command = BUS_STORE;
			mem_address = effective_address;
			mem_data    = head_data;
		end
	end

	// The entry leaves only when memory takes it
	assign sq_pop = store_issue && mem_accept;

endmodule

`default_nettype wire

//--- design/store_queue.sv
/*
 * Store queue
 * Circular buffer of stores in dispatch order; waiting operands wake
 * from the result bus, a mispredict empties it
 */
`timescale 1ns/10ps
`default_nettype none
`include "lsq_consts.svh"

module store_queue (
	input  wire                    clock,
	input  wire                    reset,
	input  wire                    sq_push,
	input  wire  lsq_pkg::rob_idx_t push_rob_idx,
	input  wire  lsq_pkg::word_t   push_opa,
	input  wire  lsq_pkg::word_t   push_opb,
	input  wire                    push_opb_valid,
	input  wire  lsq_pkg::word_t   push_rega,
	input  wire                    push_rega_valid,
	input  wire                    bus_valid,
	input  wire  lsq_pkg::prf_tag_t bus_tag,
	input  wire  lsq_pkg::word_t   bus_value,
	input  wire                    mispredict,
	input  wire                    sq_pop,
	output logic                   head_valid,
	output logic                   head_ready,
	output lsq_pkg::rob_idx_t      head_rob_idx,
	output lsq_pkg::word_t         head_opa,
	output lsq_pkg::word_t         head_opb,
	output lsq_pkg::word_t         head_data,
	output logic                   sq_full
);
	import lsq_pkg::*;

	localparam int CNT_W = $clog2(`LSQ_SQ_DEPTH) + 1;
	localparam int TAG_W = $bits(prf_tag_t);

	// Entry payload
	rob_idx_t  rob_idx_q [`LSQ_SQ_DEPTH];
	word_t     opa_q     [`LSQ_SQ_DEPTH];
	word_t     opb_q     [`LSQ_SQ_DEPTH]; // Value, or tag in the low bits
	word_t     data_q    [`LSQ_SQ_DEPTH]; // Store data, or tag in the low bits

	logic [`LSQ_SQ_DEPTH-1:0] opb_valid_q;
	logic [`LSQ_SQ_DEPTH-1:0] data_valid_q;
	logic [`LSQ_SQ_DEPTH-1:0] opb_wake;
	logic [`LSQ_SQ_DEPTH-1:0] data_wake;

	sq_idx_t          head;
	sq_idx_t          tail;
	logic [CNT_W-1:0] count;

	//////////////////////////////////////////////////
	// Tag match against the result bus
	//////////////////////////////////////////////////
	always_comb begin
		for (int i = 0; i < `LSQ_SQ_DEPTH; i++) begin
			opb_wake[i]  = bus_valid && !opb_valid_q[i] &&
				bus_tag == opb_q[i][TAG_W-1:0];
			data_wake[i] = bus_valid && !data_valid_q[i] &&
				bus_tag == data_q[i][TAG_W-1:0];
		end
	end

	//////////////////////////////////////////////////
	// Pointers, occupancy and operand valid bits
	//////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			head         <= '0;
			tail         <= '0;
			count        <= '0;
			opb_valid_q  <= '0;
			data_valid_q <= '0;
		end else if (mispredict) begin
			tail  <= head; // Drop every held store
			count <= '0;
		end else begin
			opb_valid_q  <= opb_valid_q | opb_wake;
			data_valid_q <= data_valid_q | data_wake;
			if (sq_push) begin
				opb_valid_q[tail]  <= push_opb_valid;
				data_valid_q[tail] <= push_rega_valid;
				tail               <= tail + sq_idx_t'(1);
			end
			if (sq_pop) begin
				head <= head + sq_idx_t'(1);
			end
			count <= count + CNT_W'(sq_push) - CNT_W'(sq_pop);
		end
	end

	// Payload writes and operand wakeup
	always_ff @(posedge clock) begin
		for (int i = 0; i < `LSQ_SQ_DEPTH; i++) begin
			if (opb_wake[i]) begin
				opb_q[i] <= bus_value;
			end
			if (data_wake[i]) begin
				data_q[i] <= bus_value;
			end
		end
		if (sq_push) begin
			rob_idx_q[tail] <= push_rob_idx;
			opa_q[tail]     <= push_opa;
			opb_q[tail]     <= push_opb;
			data_q[tail]    <= push_rega;
		end
	end

	//////////////////////////////////////////////////
	// Head entry and status
	//////////////////////////////////////////////////
	assign head_valid   = count != '0 && !mispredict; // No issue in the flush cycle
	assign head_ready   = opb_valid_q[head] && data_valid_q[head];
	assign head_rob_idx = rob_idx_q[head];
	assign head_opa     = opa_q[head];
	assign head_opb     = opb_q[head];
	assign head_data    = data_q[head];
	assign sq_full      = count == CNT_W'(`LSQ_SQ_DEPTH);

endmodule

`default_nettype wire

//--- design/lsq_dispatch.sv
/*
 * LSQ dispatch stage
 * Decodes the dispatched op, catches operands off the result bus,
 * pushes stores into the store queue and returns LDA sums a cycle later
 */
`timescale 1ns/10ps
`default_nettype none
`include "lsq_consts.svh"

module lsq_dispatch (
	input  wire                   clock,
	input  wire                   reset,
	input  wire                   dispatch_valid,
	input  wire  [5:0]            dispatch_op,
	input  wire  lsq_pkg::rob_idx_t dispatch_rob_idx,
	input  wire  lsq_pkg::prf_tag_t dispatch_dest_tag,
	input  wire  lsq_pkg::word_t  opa,
	input  wire  lsq_pkg::word_t  opb,
	input  wire                   opb_valid,
	input  wire  lsq_pkg::word_t  rega,
	input  wire                   rega_valid,
	input  wire                   bus_valid,
	input  wire  lsq_pkg::prf_tag_t bus_tag,
	input  wire  lsq_pkg::word_t  bus_value,
	input  wire                   mispredict,
	output logic                  sq_push,
	output lsq_pkg::rob_idx_t     push_rob_idx,
	output lsq_pkg::word_t        push_opa,
	output lsq_pkg::word_t        push_opb,
	output logic                  push_opb_valid,
	output lsq_pkg::word_t        push_rega,
	output logic                  push_rega_valid,
	output logic                  result_valid,
	output lsq_pkg::prf_tag_t     result_tag,
	output lsq_pkg::rob_idx_t     result_rob_idx,
	output lsq_pkg::word_t        result_value
);
	import lsq_pkg::*;

	localparam int TAG_W = $bits(prf_tag_t);

	mem_op_t  dispatch_type;
	word_t    opb_resolved;
	logic     opb_resolved_valid;
	word_t    rega_resolved;
	logic     rega_resolved_valid;
	logic     lda_fire;

	// Only STQ and LDA decode; locked and conditional forms are no-ops
	always_comb begin
		case (dispatch_op)
			`LSQ_OP_STQ: dispatch_type = MEM_STORE;
			`LSQ_OP_LDA: dispatch_type = MEM_LDA;
			default:     dispatch_type = MEM_NONE;
		endcase
	end

	//////////////////////////////////////////////////
	// Result bus bypass at dispatch
	//////////////////////////////////////////////////
	always_comb begin
		opb_resolved        = opb;
		opb_resolved_valid  = opb_valid;
		rega_resolved       = rega;
		rega_resolved_valid = rega_valid;
		if (bus_valid && !opb_valid && bus_tag == opb[TAG_W-1:0]) begin
			opb_resolved       = bus_value;
			opb_resolved_valid = 1'b1;
		end
		if (bus_valid && !rega_valid && bus_tag == rega[TAG_W-1:0]) begin
			rega_resolved       = bus_value;
			rega_resolved_valid = 1'b1;
		end
	end

	// No store push during a flush
	assign sq_push         = dispatch_valid && dispatch_type == MEM_STORE && !mispredict;
	assign push_rob_idx    = dispatch_rob_idx;
	assign push_opa        = opa;
	assign push_opb        = opb_resolved;
	assign push_opb_valid  = opb_resolved_valid;
	assign push_rega       = rega_resolved;
	assign push_rega_valid = rega_resolved_valid;

	//////////////////////////////////////////////////
	// LDA result, one cycle after dispatch
	//////////////////////////////////////////////////
	assign lda_fire = dispatch_valid && dispatch_type == MEM_LDA; // Not cancelled by mispredict

	always_ff @(posedge clock) begin
		if (reset) begin
			result_valid <= 1'b0;
		end else begin
			result_valid <= lda_fire;
		end
	end

	always_ff @(posedge clock) begin
		if (lda_fire) begin
			result_tag     <= dispatch_dest_tag;
			result_rob_idx <= dispatch_rob_idx;
			result_value   <= opa + opb_resolved; // Effective address
		end
	end

endmodule

`default_nettype wire

//--- design/lsq_pkg.sv
/*
 * Load/store queue package
 * Word, tag and index types and the op and memory command encodings
 */
`default_nettype none
`include "lsq_consts.svh"

package lsq_pkg;

	typedef logic [`LSQ_XLEN-1:0]              word_t;
	typedef logic [$clog2(`LSQ_PRF_SIZE)-1:0]  prf_tag_t;
	typedef logic [$clog2(`LSQ_ROB_SIZE)-1:0]  rob_idx_t;
	typedef logic [$clog2(`LSQ_SQ_DEPTH)-1:0]  sq_idx_t;

	// Decoded memory op
	typedef enum logic [1:0] {
		MEM_NONE,
		MEM_STORE,
		MEM_LDA
	} mem_op_t;

	// Command towards the data memory
	typedef enum logic [1:0] {
		BUS_NONE,
		BUS_STORE
	} bus_command_t;

endpackage

`default_nettype wire

//--- include/lsq_consts.svh
/*
 * Load/store queue constants
 * Data width, register and reorder-buffer sizes, store-queue depth, opcodes
 */
`ifndef LSQ_CONSTS_SVH
`define LSQ_CONSTS_SVH

//////////////////////////////////////////////////
// Sizes
//////////////////////////////////////////////////
`define LSQ_XLEN      64 // Operand, address and data width
`define LSQ_PRF_SIZE  64 // Physical registers
`define LSQ_ROB_SIZE  32 // Reorder-buffer entries
`define LSQ_SQ_DEPTH  8  // Store-queue entries

//////////////////////////////////////////////////
// Memory op opcodes
//////////////////////////////////////////////////
`define LSQ_OP_LDA    6'h08 // Address compute
`define LSQ_OP_STQ    6'h2d // Quadword store

`endif
